/* Bender.yml */
package:
  name: rs_decode

sources:
  - files:
      - common/RsDecodePkg.sv
      - gf/RsDecodeInv.sv
      - gf/RsGfMult.sv
      - design/RsSyndrome.sv
      - design/RsLocator.sv
      - design/RsDelayBuffer.sv
      - design/RsCorrector.sv
      - design/RsDecodeTop.sv
  - target: simulation
    files:
      - tb/tb_RsDecodeTop.sv

/* common/RsDecodePkg.sv */
// Shared types and GF(256) helpers for the RS(n, n-2) decoder
// Field polynomial x^8+x^4+x^3+x^2+1, generator roots alpha^0 and alpha^1

package RsDecodePkg;

   localparam int symbolWidth = 8;

   typedef logic [symbolWidth-1:0] symbol_t;

   typedef struct packed {
      logic    start;
      logic    enable;
      symbol_t symbol;
   } symbolBeat_t;

   typedef struct packed {
      symbol_t s0;
      symbol_t s1;
   } syndromePair_t;

   typedef struct packed {
      symbol_t locator;   // alpha^p of the bad symbol
      symbol_t magnitude;
      logic    singleError;
      logic    uncorrectable;
   } locatorInfo_t;

   typedef struct packed {
      logic done;
      logic corrected;
      logic failure;
   } decodeStatus_t;

   localparam symbol_t gfAlpha    = 8'd2;
   localparam symbol_t gfAlphaInv = 8'd142;
   localparam symbol_t gfPolyLow  = 8'h1d;   // Low byte of 0x11d

   function automatic symbol_t gfTimesAlpha(input symbol_t x);
      return x[7] ? ({x[6:0], 1'b0} ^ gfPolyLow) : {x[6:0], 1'b0};
   endfunction

   // alpha^exponent, exponent taken mod 255
   function automatic symbol_t gfPower(input int exponent);
      symbol_t result;
      result = 8'd1;
      for (int i = 0; i < exponent % 255; i++) begin
         result = gfTimesAlpha(result);
      end
      return result;
   endfunction

endpackage

/* design/RsCorrector.sv */
// Output corrector
// Steps the position power from alpha^(n-1) down to alpha^0 along the codeword,
// flips the symbol whose power matches the locator, reports status at the end

module RsCorrector #(
   parameter int codeLength = 255
) (
   input  logic                      clk,
   input  logic                      reset,
   input  RsDecodePkg::symbolBeat_t   delayed,
   input  RsDecodePkg::locatorInfo_t  info,
   output RsDecodePkg::symbolBeat_t   decoded,
   output RsDecodePkg::decodeStatus_t status
);
   import RsDecodePkg::*;

   localparam symbol_t startPower = gfPower(codeLength - 1);

   locatorInfo_t held;        // Info of the codeword being output
   locatorInfo_t curInfo;
   symbol_t      power;
   symbol_t      curPower;
   symbol_t      nextPower;
   logic         matchSeen;
   logic         matchAll;
   logic         isStart;
   logic         hit;
   logic         lastSymbol;

   RsGfMult stepDown (
      .a      (curPower),
      .b      (gfAlphaInv),
      .product(nextPower)
   );

   assign isStart  = delayed.enable && delayed.start;
   assign curInfo  = isStart ? info : held;
   assign curPower = isStart ? startPower : power;
   assign hit      = delayed.enable && curInfo.singleError && (curPower == curInfo.locator);
   assign matchAll = hit || (!isStart && matchSeen);
   // Power 1 only at the last symbol
   assign lastSymbol = delayed.enable && (curPower == 8'd1);

   always_ff @(posedge clk) begin
      if (reset) begin
         held           <= '0;
         power          <= '0;
         matchSeen      <= 1'b0;
         decoded.enable <= 1'b0;
         decoded.start  <= 1'b0;
         status         <= '0;
      end else begin
         if (isStart) begin
            held <= info;
         end
         if (delayed.enable) begin
            power     <= nextPower;
            matchSeen <= matchAll;
         end
         decoded.enable   <= delayed.enable;
         decoded.start    <= isStart;
         status.done      <= lastSymbol;
         status.corrected <= lastSymbol && matchAll;
         status.failure   <= lastSymbol &&
                             (curInfo.uncorrectable || (curInfo.singleError && !matchAll));
      end
      decoded.symbol <= delayed.symbol ^ (hit ? curInfo.magnitude : '0);
   end

endmodule

/* design/RsDecodeTop.sv */
// Single-error RS decoder over GF(256), two parity symbols
// Syndromes and locator run alongside a delay line, the corrector fixes symbols on the way out

module RsDecodeTop #(
   parameter int codeLength = 255
) (
   input  logic                      clk,
   input  logic                      reset,
   input  RsDecodePkg::symbolBeat_t   received,
   output RsDecodePkg::symbolBeat_t   decoded,
   output RsDecodePkg::decodeStatus_t status
);
   import RsDecodePkg::*;

   syndromePair_t syndromes;
   logic          syndromeValid;
   locatorInfo_t  info;
   symbolBeat_t   delayedBeat;

   // ============================================================
   // Syndrome and locator path
   // ============================================================
   RsSyndrome syndrome_inst (
      .clk          (clk),
      .reset        (reset),
      .beat         (received),
      .syndromes    (syndromes),
      .syndromeValid(syndromeValid)
   );

   RsLocator locator_inst (
      .clk          (clk),
      .reset        (reset),
      .syndromes    (syndromes),
      .syndromeValid(syndromeValid),
      .info         (info)
   );

   // ============================================================
   // Data path
   // ============================================================
   RsDelayBuffer #(
      .codeLength(codeLength)
   ) delayBuffer_inst (
      .clk    (clk),
      .reset  (reset),
      .beat   (received),
      .delayed(delayedBeat)
   );

   RsCorrector #(
      .codeLength(codeLength)
   ) corrector_inst (
      .clk    (clk),
      .reset  (reset),
      .delayed(delayedBeat),
      .info   (info),
      .decoded(decoded),
      .status (status)
   );

endmodule

/* design/RsDelayBuffer.sv */
// Fixed delay line for received beats
// Circular memory of codeLength+1 entries, read then written at one pointer

module RsDelayBuffer #(
   parameter int codeLength = 255
) (
   input  logic                    clk,
   input  logic                    reset,
   input  RsDecodePkg::symbolBeat_t beat,
   output RsDecodePkg::symbolBeat_t delayed
);
   import RsDecodePkg::*;

   localparam int depth    = codeLength + 1;
   localparam int ptrWidth = $clog2(depth);

   logic [ptrWidth-1:0] ptr;
   logic [depth-1:0]    enableMem;
   logic [depth-1:0]    startMem;
   symbol_t             symbolMem [depth];

   always_ff @(posedge clk) begin
      if (reset) begin
         ptr            <= '0;
         enableMem      <= '0;   // No stale beats after reset
         startMem       <= '0;
         delayed.enable <= 1'b0;
         delayed.start  <= 1'b0;
      end else begin
         delayed.enable <= enableMem[ptr];
         delayed.start  <= startMem[ptr];
         enableMem[ptr] <= beat.enable;
         startMem[ptr]  <= beat.start && beat.enable;
         ptr            <= (ptr == ptrWidth'(depth - 1)) ? '0 : ptr + 1'b1;
      end
      delayed.symbol <= symbolMem[ptr];
      symbolMem[ptr] <= beat.symbol;
   end

endmodule

/* design/RsLocator.sv */
// Single-error locator
// Error position alpha^p = S1 / S0 and error value S0, registered on syndromeValid

module RsLocator (
   input  logic                      clk,
   input  logic                      reset,
   input  RsDecodePkg::syndromePair_t syndromes,
   input  logic                      syndromeValid,
   output RsDecodePkg::locatorInfo_t  info
);
   import RsDecodePkg::*;

   symbol_t s0Inv;
   symbol_t ratio;
   logic    s0Zero;
   logic    s1Zero;

   RsDecodeInv s0Inverse (
      .B(syndromes.s0),
      .R(s0Inv)
   );

   RsGfMult ratioMult (
      .a      (syndromes.s1),
      .b      (s0Inv),
      .product(ratio)
   );

   assign s0Zero = (syndromes.s0 == '0);
   assign s1Zero = (syndromes.s1 == '0);

   // ============================================================
   // Classification
   // ============================================================
   always_ff @(posedge clk) begin
      if (reset) begin
         info.singleError   <= 1'b0;
         info.uncorrectable <= 1'b0;
      end else if (syndromeValid) begin
         info.singleError   <= !s0Zero && !s1Zero;
         info.uncorrectable <= s0Zero ^ s1Zero;   // Not a single-error pattern
      end
      if (syndromeValid) begin
         info.locator   <= ratio;
         info.magnitude <= syndromes.s0;
      end
   end

endmodule

/* design/RsSyndrome.sv */
// Syndrome accumulator
// S0 is the XOR sum of the codeword, S1 the codeword evaluated at alpha by Horner

module RsSyndrome (
   input  logic                      clk,
   input  logic                      reset,
   input  RsDecodePkg::symbolBeat_t   beat,
   output RsDecodePkg::syndromePair_t syndromes,
   output logic                      syndromeValid
);
   import RsDecodePkg::*;

   syndromePair_t acc;
   symbol_t       s1Shifted;
   logic          inWord;
   logic          wordEnd;

   RsGfMult alphaMult (
      .a      (acc.s1),
      .b      (gfAlpha),
      .product(s1Shifted)
   );

   // Previous cycle held the last symbol
   assign wordEnd = inWord && (!beat.enable || beat.start);

   always_ff @(posedge clk) begin
      if (reset) begin
         inWord        <= 1'b0;
         syndromeValid <= 1'b0;
      end else begin
         inWord        <= beat.enable;
         syndromeValid <= wordEnd;
      end
   end

   // ============================================================
   // Accumulation
   // ============================================================
   always_ff @(posedge clk) begin
      if (beat.enable && beat.start) begin
         acc.s0 <= beat.symbol;
         acc.s1 <= beat.symbol;
      end else if (beat.enable) begin
         acc.s0 <= acc.s0 ^ beat.symbol;
         acc.s1 <= s1Shifted ^ beat.symbol;
      end
      if (wordEnd) begin
         syndromes <= acc;   // Free acc for the next codeword
      end
   end

endmodule

/* gf/RsDecodeInv.sv */
// GF(256) multiplicative inverse
// Constant lookup, zero maps to zero

module RsDecodeInv (
   input  RsDecodePkg::symbol_t B,
   output RsDecodePkg::symbol_t R
);
   import RsDecodePkg::*;

   // Indexed by B
   localparam symbol_t invTable [0:255] = '{
      8'd0,   8'd1,   8'd142, 8'd244,
      8'd71,  8'd167, 8'd122, 8'd186,
      8'd173, 8'd157, 8'd221, 8'd152,
      8'd61,  8'd170, 8'd93,  8'd150,
      8'd216, 8'd114, 8'd192, 8'd88,
      8'd224, 8'd62,  8'd76,  8'd102,
      8'd144, 8'd222, 8'd85,  8'd128,
      8'd160, 8'd131, 8'd75,  8'd42,
      8'd108, 8'd237, 8'd57,  8'd81,
      8'd96,  8'd86,  8'd44,  8'd138,
      8'd112, 8'd208, 8'd31,  8'd74,
      8'd38,  8'd139, 8'd51,  8'd110,
      8'd72,  8'd137, 8'd111, 8'd46,
      8'd164, 8'd195, 8'd64,  8'd94,
      8'd80,  8'd34,  8'd207, 8'd169,
      8'd171, 8'd12,  8'd21,  8'd225,
      8'd54,  8'd95,  8'd248, 8'd213,
      8'd146, 8'd78,  8'd166, 8'd4,
      8'd48,  8'd136, 8'd43,  8'd30,
      8'd22,  8'd103, 8'd69,  8'd147,
      8'd56,  8'd35,  8'd104, 8'd140,
      8'd129, 8'd26,  8'd37,  8'd97,
      8'd19,  8'd193, 8'd203, 8'd99,
      8'd151, 8'd14,  8'd55,  8'd65,
      8'd36,  8'd87,  8'd202, 8'd91,
      8'd185, 8'd196, 8'd23,  8'd77,
      8'd82,  8'd141, 8'd239, 8'd179,
      8'd32,  8'd236, 8'd47,  8'd50,
      8'd40,  8'd209, 8'd17,  8'd217,
      8'd233, 8'd251, 8'd218, 8'd121,
      8'd219, 8'd119, 8'd6,   8'd187,
      8'd132, 8'd205, 8'd254, 8'd252,
      8'd27,  8'd84,  8'd161, 8'd29,
      8'd124, 8'd204, 8'd228, 8'd176,
      8'd73,  8'd49,  8'd39,  8'd45,
      8'd83,  8'd105, 8'd2,   8'd245,
      8'd24,  8'd223, 8'd68,  8'd79,
      8'd155, 8'd188, 8'd15,  8'd92,
      8'd11,  8'd220, 8'd189, 8'd148,
      8'd172, 8'd9,   8'd199, 8'd162,
      8'd28,  8'd130, 8'd159, 8'd198,
      8'd52,  8'd194, 8'd70,  8'd5,
      8'd206, 8'd59,  8'd13,  8'd60,
      8'd156, 8'd8,   8'd190, 8'd183,
      8'd135, 8'd229, 8'd238, 8'd107,
      8'd235, 8'd242, 8'd191, 8'd175,
      8'd197, 8'd100, 8'd7,   8'd123,
      8'd149, 8'd154, 8'd174, 8'd182,
      8'd18,  8'd89,  8'd165, 8'd53,
      8'd101, 8'd184, 8'd163, 8'd158,
      8'd210, 8'd247, 8'd98,  8'd90,
      8'd133, 8'd125, 8'd168, 8'd58,
      8'd41,  8'd113, 8'd200, 8'd246,
      8'd249, 8'd67,  8'd215, 8'd214,
      8'd16,  8'd115, 8'd118, 8'd120,
      8'd153, 8'd10,  8'd25,  8'd145,
      8'd20,  8'd63,  8'd230, 8'd240,
      8'd134, 8'd177, 8'd226, 8'd241,
      8'd250, 8'd116, 8'd243, 8'd180,
      8'd109, 8'd33,  8'd178, 8'd106,
      8'd227, 8'd231, 8'd181, 8'd234,
      8'd3,   8'd143, 8'd211, 8'd201,
      8'd66,  8'd212, 8'd232, 8'd117,
      8'd127, 8'd255, 8'd126, 8'd253
   };

   assign R = invTable[B];

endmodule

/* gf/RsGfMult.sv */
// GF(256) multiplier
// Shift-and-add over the bits of b, reduced by x^8+x^4+x^3+x^2+1 on each shift

module RsGfMult (
   input  RsDecodePkg::symbol_t a,
   input  RsDecodePkg::symbol_t b,
   output RsDecodePkg::symbol_t product
);
   import RsDecodePkg::*;

   always_comb begin : shiftAdd
      symbol_t acc;
      symbol_t shifted;
      acc     = '0;
      shifted = a;   // a * alpha^i
      for (int i = 0; i < symbolWidth; i++) begin
         if (b[i]) begin
            acc = acc ^ shifted;
         end
         shifted = gfTimesAlpha(shifted);
      end
      product = acc;
   end

endmodule

/* list.f */
common/RsDecodePkg.sv
gf/RsDecodeInv.sv
gf/RsGfMult.sv
design/RsSyndrome.sv
design/RsLocator.sv
design/RsDelayBuffer.sv
design/RsCorrector.sv
design/RsDecodeTop.sv
tb/tb_RsDecodeTop.sv

/* tb/tb_RsDecodeTop.sv */
// Testbench for the single-error RS decoder
// Encodes random messages, injects errors from a case table, checks decoded
// symbols, timing and per-codeword status against a reference model

module tb_RsDecodeTop;
   timeunit 1ns;
   timeprecision 1ps;

   import RsDecodePkg::*;

   localparam int codeLength = 15;
   localparam int numCases   = 11;
   localparam int gapCycles  = 3;
   localparam int cycleLimit = (numCases + 2) * (codeLength + 4) + 20;

   typedef struct packed {
      logic [1:0] errCount;
      logic [7:0] pos0;
      symbol_t    val0;
      logic [7:0] pos1;
      symbol_t    val1;
      logic       backToBack;
   } caseEntry_t;

   typedef struct packed {
      symbolBeat_t   beat;
      decodeStatus_t status;
      logic [31:0]   due;   // Cycle at which the beat must appear
   } expected_t;

   logic          clk;
   logic          reset;
   symbolBeat_t   received;
   symbolBeat_t   decoded;
   decodeStatus_t status;

   caseEntry_t    caseTable [numCases];
   symbol_t       txWord [codeLength];
   symbol_t       rxWord [codeLength];
   symbol_t       expWord [codeLength];
   decodeStatus_t expStatus;
   expected_t     expQueue [$];
   logic [31:0]   lcgState = 32'h41ed5abd;
   int unsigned   cycle = 0;

   RsDecodeTop #(
      .codeLength(codeLength)
   ) RsDecodeTop_inst (
      .clk     (clk),
      .reset   (reset),
      .received(received),
      .decoded (decoded),
      .status  (status)
   );

   initial clk = 1'b0;

   always begin
      #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   always @(posedge clk) begin
      if (cycle >= cycleLimit) begin
         $display("Timeout: decoder output did not finish within %0d cycles", cycleLimit);
         $display("Simulation finished: FAIL");
         $fatal(1, "Run stopped by the cycle limit");
      end
   end

   // ============================================================
   // Reference model
   // ============================================================
   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // MSB first, reduce by 0x11d
   function automatic symbol_t gfMul(input symbol_t a, input symbol_t b);
      symbol_t p;
      p = '0;
      for (int i = 7; i >= 0; i--) begin
         p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1d : 8'h00);
         if (b[i]) begin
            p = p ^ a;
         end
      end
      return p;
   endfunction

   function automatic symbol_t alphaPow(input int n);
      symbol_t x;
      x = 8'd1;
      for (int i = 0; i < n; i++) begin
         x = gfMul(x, 8'd2);
      end
      return x;
   endfunction

   task automatic addCase(input int idx, input int count, input int p0, input symbol_t v0,
                          input int p1, input symbol_t v1, input bit b2b);
      caseTable[idx].errCount   = count;
      caseTable[idx].pos0       = p0;
      caseTable[idx].val0       = v0;
      caseTable[idx].pos1       = p1;
      caseTable[idx].val1       = v1;
      caseTable[idx].backToBack = b2b;
   endtask

   // Systematic encoder, generator x^2+3x+2, parity in the last two symbols
   task automatic encodeCodeword();
      symbol_t fb;
      symbol_t r0;
      symbol_t r1;
      r0 = '0;
      r1 = '0;
      for (int i = 0; i < codeLength - 2; i++) begin
         lcgState  = lcgNext(lcgState);
         txWord[i] = lcgState[31:24];
         fb        = txWord[i] ^ r1;
         r1        = r0 ^ gfMul(fb, 8'd3);
         r0        = gfMul(fb, 8'd2);
      end
      txWord[codeLength-2] = r1;
      txWord[codeLength-1] = r0;
   endtask

   task automatic computeSyndromes(output syndromePair_t syn);
      syn = '0;
      for (int i = 0; i < codeLength; i++) begin
         syn.s0 = syn.s0 ^ rxWord[i];
         syn.s1 = gfMul(syn.s1, 8'd2) ^ rxWord[i];
      end
   endtask

   task automatic injectErrors(input int idx);
      syndromePair_t syn;
      for (int i = 0; i < codeLength; i++) begin
         rxWord[i] = txWord[i];
      end
      computeSyndromes(syn);
      if (syn != '0) begin
         $display("Reference encoder built a word with nonzero syndromes in case %0d", idx);
         $display("Simulation finished: FAIL");
         $fatal(1, "Reference encoder is broken");
      end
      if (caseTable[idx].errCount >= 1) begin
         rxWord[caseTable[idx].pos0] ^= caseTable[idx].val0;
      end
      if (caseTable[idx].errCount >= 2) begin
         rxWord[caseTable[idx].pos1] ^= caseTable[idx].val1;
      end
   endtask

   task automatic predictOutput();
      syndromePair_t syn;
      int            fixIndex;
      fixIndex  = -1;
      expStatus = '0;
      expStatus.done = 1'b1;
      computeSyndromes(syn);
      if (syn.s0 != '0 && syn.s1 != '0) begin
         for (int p = 0; p < codeLength; p++) begin
            if (gfMul(syn.s0, alphaPow(p)) == syn.s1) begin   // s1 = s0 * alpha^p
               fixIndex = codeLength - 1 - p;
            end
         end
         expStatus.corrected = (fixIndex >= 0);
         expStatus.failure   = (fixIndex < 0);   // Locator outside the shortened word
      end else if (syn.s0 != '0 || syn.s1 != '0) begin
         expStatus.failure = 1'b1;
      end
      for (int i = 0; i < codeLength; i++) begin
         expWord[i] = rxWord[i] ^ ((i == fixIndex) ? syn.s0 : 8'h00);
      end
   endtask

   // ============================================================
   // Stimulus
   // ============================================================
   task automatic idleCycle();
      @(posedge clk);
      received <= '0;
   endtask

   task automatic driveCodeword();
      symbolBeat_t beat;
      expected_t   want;
      for (int i = 0; i < codeLength; i++) begin
         @(posedge clk);
         beat.start  = (i == 0);
         beat.enable = 1'b1;
         beat.symbol = rxWord[i];
         received <= beat;
         want.beat        = beat;
         want.beat.symbol = expWord[i];
         want.status      = (i == codeLength - 1) ? expStatus : '0;
         want.due         = cycle + codeLength + 4;   // Sampled next edge, then n+2 edges
         expQueue.push_back(want);
      end
   endtask

   initial begin : stimulus
      $timeformat(-9, 0, " ns", 0);
      reset    = 1'b1;
      received = '0;
      addCase(0, 0, 0, 8'h00, 0, 8'h00, 1'b0);    // Clean
      addCase(1, 1, 0, 8'h5a, 0, 8'h00, 1'b1);    // First symbol
      addCase(2, 1, 14, 8'h01, 0, 8'h00, 1'b1);   // Last symbol
      addCase(3, 1, 7, 8'hff, 0, 8'h00, 1'b1);
      addCase(4, 2, 3, 8'h33, 9, 8'h33, 1'b0);    // S0 zero
      addCase(5, 2, 13, 8'h01, 14, 8'h02, 1'b1);  // S1 zero
      addCase(6, 1, 1, 8'h80, 0, 8'h00, 1'b0);
      addCase(7, 0, 0, 8'h00, 0, 8'h00, 1'b1);
      addCase(8, 1, 12, 8'h10, 0, 8'h00, 1'b1);
      addCase(9, 1, 5, 8'hc4, 0, 8'h00, 1'b0);
      addCase(10, 2, 13, 8'h1d, 14, 8'h1c, 1'b1); // Locator alpha^15, past the word
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      for (int c = 0; c < numCases; c++) begin
         if (!caseTable[c].backToBack) begin
            repeat (gapCycles) idleCycle();
         end
         encodeCodeword();
         injectErrors(c);
         predictOutput();
         driveCodeword();
      end
      idleCycle();
      while (expQueue.size() != 0) begin
         @(posedge clk);
      end
      repeat (codeLength + 4) @(posedge clk);   // No stray output afterwards
      $display("Simulation finished: PASS");
      $finish;
   end

   // ============================================================
   // Checks
   // ============================================================
   task automatic checkBeat(input symbolBeat_t got, input symbolBeat_t want);
      if (got.start !== want.start || got.enable !== want.enable ||
          (want.enable && got.symbol !== want.symbol)) begin
         $display("Error: %0t: decoded start=%0b enable=%0b symbol=%02h, expected %0b %0b %02h",
                  $time, got.start, got.enable, got.symbol,
                  want.start, want.enable, want.symbol);
         $display("Simulation finished: FAIL");
         $fatal(1, "Decoded beat mismatch");
      end
   endtask

   task automatic checkStatus(input decodeStatus_t got, input decodeStatus_t want);
      if (got !== want) begin
         $display("Error: %0t: status done=%0b corrected=%0b failure=%0b, expected %0b %0b %0b",
                  $time, got.done, got.corrected, got.failure,
                  want.done, want.corrected, want.failure);
         $display("Simulation finished: FAIL");
         $fatal(1, "Status mismatch");
      end
   endtask

   always @(negedge clk) begin : outputCheck
      expected_t want;
      if (!reset) begin
         if (expQueue.size() != 0 && expQueue[0].due == cycle) begin
            want = expQueue.pop_front();
         end else begin
            want = '0;   // Idle, nothing due this cycle
         end
         checkBeat(decoded, want.beat);
         checkStatus(status, want.status);
      end
   end

endmodule
